//--- snake_game.f
+incdir+.
snake_pkg.sv
snake_head.sv
snake_segment.sv
coin_gen.sv
pixel_render.sv
snake_game.sv
snake_game_tb.sv

//--- Bender.yml
package:
  name: snake_game

sources:
  - include_dirs:
      - .
    files:
      - snake_pkg.sv
      - snake_head.sv
      - snake_segment.sv
      - coin_gen.sv
      - pixel_render.sv
      - snake_game.sv
  - target: test
    files:
      - snake_game_tb.sv

//--- snake_game_vectors.txt
# t: move_valid move ticks (move 0 right, 1 up, 2 left, 3 down); r: reset
# s: head_x head_y score game_over; q: eval_x eval_y colour valid; all hex
# Reset state, start body and first coin
s 0a 0a 00 0
q 01e 01e ff 1
q 01d 01f ff 1
q 01a 01e ff 1
q 018 01e 00 1
q 026 01e fc 1
# Window edges
q 009 01e 00 0
q 04a 01e 00 0
q 01e 049 00 1
q 01e 04a 00 0
# Right with a reversal ignored, then eat at 14,10
t 0 0 1
t 1 2 1
s 0c 0a 00 0
t 0 0 2
s 0e 0a 01 0
q 022 018 fc 1
q 020 01e ff 1
q 01e 01e 00 1
# Up and left onto the coin at 12,7
t 1 1 3
s 0e 07 01 0
t 1 2 2
s 0c 07 02 0
q 042 022 fc 1
q 026 01c ff 1
q 026 01e 00 1
# Turn back into the body
t 1 3 1
t 1 0 1
s 0d 08 02 0
t 1 1 1
s 0d 08 02 1
t 0 0 2
s 0d 08 02 1
# Top wall after a fresh reset
r
t 1 1 0a
s 0a 00 00 0
t 0 0 2
s 0a 00 00 1
q 01e 00a ff 1
q 01e 00e ff 1
q 01e 010 00 1

//--- snake_game_tb.sv
`timescale 1ns/1ps

module snake_game_tb;

	import snake_pkg::*;

	logic       clk;
	logic       reset;
	logic       game_tick;
	logic       move_valid;
	dir_t       move;
	logic [9:0] eval_x;
	logic [9:0] eval_y;
	logic       game_over;
	score_t     score;
	cell_x_t    head_x;
	cell_y_t    head_y;
	colour_t    out_color;
	logic       color_valid;
	int         cycles;
	int         cycle_limit;

	snake_game dut_i (.*);

	always #20 clk = ~clk; // 40 ns period

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("Timeout: the vectors did not finish within %0d cycles", cycle_limit);
			fail_run();
		end
	end

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic fail_run();
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_cell(input cell_x_t got_x, input cell_y_t got_y,
		input cell_x_t exp_x, input cell_y_t exp_y);
		if (got_x !== exp_x || got_y !== exp_y) begin
			$display("Error head_x/head_y: got %h/%h expected %h/%h",
				got_x, got_y, exp_x, exp_y);
			fail_run();
		end
	endtask

	task automatic check_score(input score_t got, input score_t exp);
		if (got !== exp) begin
			$display("Error score: got %h expected %h", got, exp);
			fail_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error %s: got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_colour(input colour_t got, input colour_t exp);
		if (got !== exp) begin
			$display("Error out_color: got %h expected %h", got, exp);
			fail_run();
		end
	endtask

	// Every operation line carries a fixed number of fields
	task automatic require_fields(input int got, input int want, input string op);
		if (got != want) begin
			$display("Vectors line '%s' has %0d fields instead of %0d", op, got, want);
			fail_run();
		end
	endtask

	////////////////////////////////////////
	// Drive tasks, each ends on a falling edge
	////////////////////////////////////////

	task automatic apply_reset();
		reset = 1'b1;
		repeat (3) @(negedge clk);
		reset = 1'b0;
	endtask

	// Move gets its own cycle so the following tick uses it
	task automatic run_tick(input logic with_move, input dir_t dir, input int count);
		if (with_move) begin
			move_valid = 1'b1;
			move = dir;
			@(negedge clk);
			move_valid = 1'b0;
		end
		repeat (count) begin
			game_tick = 1'b1; // Back to back steps
			@(negedge clk);
		end
		game_tick = 1'b0;
	endtask

	task automatic run_query(input logic [9:0] x, input logic [9:0] y,
		input colour_t exp_colour, input logic exp_valid);
		eval_x = x;
		eval_y = y;
		@(negedge clk); // Registered one cycle later
		check_flag("color_valid", color_valid, exp_valid);
		check_colour(out_color, exp_colour);
	endtask

	initial begin : main_seq
		int    fd;
		int    r;
		int    lines;
		int    a;
		int    b;
		int    c;
		int    d;
		string op;
		string rest;

		clk = 1'b0;
		cycles = 0;
		cycle_limit = 0;
		reset = 1'b1;
		game_tick = 1'b0;
		move_valid = 1'b0;
		move = DIR_RIGHT;
		eval_x = '0;
		eval_y = '0;

		fd = $fopen("snake_game_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open snake_game_vectors.txt");
			fail_run();
		end
		lines = 0;
		while ($fgets(rest, fd) > 0)
			lines++;
		$fclose(fd);
		cycle_limit = 4 * lines + 3; // Plus the reset cycles
		fd = $fopen("snake_game_vectors.txt", "r");

		apply_reset();
		while ($fscanf(fd, "%s", op) == 1) begin
			if (op == "t") begin
				r = $fscanf(fd, "%h %h %h", a, b, c);
				require_fields(r, 3, op);
				run_tick(a[0], dir_t'(b[1:0]), c);
			end else if (op == "s") begin
				r = $fscanf(fd, "%h %h %h %h", a, b, c, d);
				require_fields(r, 4, op);
				check_cell(head_x, head_y, cell_x_t'(a), cell_y_t'(b));
				check_score(score, score_t'(c));
				check_flag("game_over", game_over, d[0]);
			end else if (op == "q") begin
				r = $fscanf(fd, "%h %h %h %h", a, b, c, d);
				require_fields(r, 4, op);
				run_query(a[9:0], b[9:0], colour_t'(c), d[0]);
			end else if (op == "r") begin
				apply_reset();
			end else if (op.getc(0) == "#") begin
				r = $fgets(rest, fd); // Rest of a comment line
			end else begin
				$display("Unknown operation '%s' in the vectors file", op);
				fail_run();
			end
		end
		$fclose(fd);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- snake_game.sv
`timescale 1ns/1ps
`include "snake_cfg.svh"

module snake_game (
	input  logic                clk,
	input  logic                reset,
	input  logic                game_tick,
	input  logic                move_valid,
	input  snake_pkg::dir_t     move,
	input  logic [9:0]          eval_x,
	input  logic [9:0]          eval_y,
	output logic                game_over,
	output snake_pkg::score_t   score,
	output snake_pkg::cell_x_t  head_x,
	output snake_pkg::cell_y_t  head_y,
	output snake_pkg::colour_t  out_color,
	output logic                color_valid
);

	import snake_pkg::*;

	localparam int NUM_SEG = `SNAKE_MAX_LEN - 1;

	logic    step;
	logic    grow;
	logic    self_hit;
	logic    body_query;
	logic    coin_query;
	cell_x_t next_x;
	cell_y_t next_y;
	cell_x_t query_x;
	cell_y_t query_y;

	// Entry 0 is the head, entry i+1 is segment i
	wire cell_x_t chain_x [`SNAKE_MAX_LEN];
	wire cell_y_t chain_y [`SNAKE_MAX_LEN];
	wire          chain_active [`SNAKE_MAX_LEN];

	wire [NUM_SEG-1:0] body_hits;
	wire [NUM_SEG-1:0] query_hits;

	snake_head head_i (
		.clk        (clk),
		.reset      (reset),
		.game_tick  (game_tick),
		.move_valid (move_valid),
		.move       (move),
		.self_hit   (self_hit),
		.step       (step),
		.next_x     (next_x),
		.next_y     (next_y),
		.head_x     (head_x),
		.head_y     (head_y),
		.game_over  (game_over)
	);

	////////////////////////////////////////
	// Body chain
	////////////////////////////////////////

	assign chain_x[0]      = head_x;
	assign chain_y[0]      = head_y;
	assign chain_active[0] = 1'b1;

	for (genvar i = 0; i < NUM_SEG; i++) begin : g_seg
		snake_segment #(.INDEX(i)) seg_i (
			.clk         (clk),
			.reset       (reset),
			.step        (step),
			.grow        (grow),
			.prev_x      (chain_x[i]),
			.prev_y      (chain_y[i]),
			.prev_active (chain_active[i]),
			.next_x      (next_x),
			.next_y      (next_y),
			.query_x     (query_x),
			.query_y     (query_y),
			.seg_x       (chain_x[i+1]),
			.seg_y       (chain_y[i+1]),
			.seg_active  (chain_active[i+1]),
			.body_hit    (body_hits[i]),
			.query_hit   (query_hits[i])
		);
	end

	assign self_hit   = |body_hits;
	assign body_query = |query_hits;

	coin_gen coin_i (
		.clk        (clk),
		.reset      (reset),
		.step       (step),
		.next_x     (next_x),
		.next_y     (next_y),
		.query_x    (query_x),
		.query_y    (query_y),
		.grow       (grow),
		.coin_query (coin_query),
		.score      (score)
	);

	pixel_render render_i (
		.clk         (clk),
		.reset       (reset),
		.eval_x      (eval_x),
		.eval_y      (eval_y),
		.query_x     (query_x),
		.query_y     (query_y),
		.head_x      (head_x),
		.head_y      (head_y),
		.body_query  (body_query),
		.coin_query  (coin_query),
		.out_color   (out_color),
		.color_valid (color_valid)
	);

endmodule

//--- pixel_render.sv
`timescale 1ns/1ps
`include "snake_cfg.svh"

module pixel_render (
	input  logic                clk,
	input  logic                reset,
	input  logic [9:0]          eval_x,
	input  logic [9:0]          eval_y,
	output snake_pkg::cell_x_t  query_x,
	output snake_pkg::cell_y_t  query_y,
	input  snake_pkg::cell_x_t  head_x,
	input  snake_pkg::cell_y_t  head_y,
	input  logic                body_query,
	input  logic                coin_query,
	output snake_pkg::colour_t  out_color,
	output logic                color_valid
);

	import snake_pkg::*;

	// Window edges in screen pixels
	localparam logic [9:0] WIN_X0 = 10'(`SNAKE_POS_X);
	localparam logic [9:0] WIN_Y0 = 10'(`SNAKE_POS_Y);
	localparam logic [9:0] WIN_X1 = 10'(`SNAKE_POS_X + (`SNAKE_H << `SNAKE_SCALE_SHIFT));
	localparam logic [9:0] WIN_Y1 = 10'(`SNAKE_POS_Y + (`SNAKE_V << `SNAKE_SCALE_SHIFT));

	logic [9:0] local_x;
	logic [9:0] local_y;
	logic       in_window;
	logic       head_query;
	cell_kind_t kind;
	colour_t    colour;

	////////////////////////////////////////
	// Screen to cell mapping
	////////////////////////////////////////

	assign local_x = eval_x - WIN_X0;
	assign local_y = eval_y - WIN_Y0;
	assign query_x = cell_x_t'(local_x >> `SNAKE_SCALE_SHIFT);
	assign query_y = cell_y_t'(local_y >> `SNAKE_SCALE_SHIFT);

	assign in_window = (eval_x >= WIN_X0) && (eval_x < WIN_X1) &&
		(eval_y >= WIN_Y0) && (eval_y < WIN_Y1);

	assign head_query = (query_x == head_x) && (query_y == head_y);

	// Snake drawn over the coin
	always_comb begin
		if (!in_window)
			kind = CELL_BG;
		else if (head_query || body_query)
			kind = CELL_SNAKE;
		else if (coin_query)
			kind = CELL_COIN;
		else
			kind = CELL_BG;
	end

	always_comb begin
		case (kind)
			CELL_SNAKE: colour = `SNAKE_COLOR_SNAKE;
			CELL_COIN:  colour = `SNAKE_COLOR_COIN;
			default:    colour = `SNAKE_COLOR_BG;
		endcase
	end

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			color_valid <= 1'b0;
		else
			color_valid <= in_window;
	end

	always_ff @(posedge clk) begin
		out_color <= colour;
	end

endmodule

//--- coin_gen.sv
`timescale 1ns/1ps
`include "snake_cfg.svh"

module coin_gen (
	input  logic                clk,
	input  logic                reset,
	input  logic                step,
	input  snake_pkg::cell_x_t  next_x,
	input  snake_pkg::cell_y_t  next_y,
	input  snake_pkg::cell_x_t  query_x,
	input  snake_pkg::cell_y_t  query_y,
	output logic                grow,
	output logic                coin_query,
	output snake_pkg::score_t   score
);

	import snake_pkg::*;

	localparam int LFSR_BITS = `SNAKE_XBITS + `SNAKE_YBITS;

	logic [LFSR_BITS-1:0] lfsr;
	logic [LFSR_BITS-1:0] lfsr_next;
	cell_x_t              coin_x;
	cell_y_t              coin_y;

	////////////////////////////////////////
	// Coin placement LFSR
	////////////////////////////////////////

	// Fibonacci form, taps 10 and 7
	assign lfsr_next = {lfsr[LFSR_BITS-2:0], lfsr[9] ^ lfsr[6]};

	always_ff @(posedge clk) begin
		if (reset)
			lfsr <= `COIN_LFSR_SEED;
		else if (step)
			lfsr <= lfsr_next;
	end

	////////////////////////////////////////
	// Eating and score
	////////////////////////////////////////

	assign grow = step && (next_x == coin_x) && (next_y == coin_y);

	always_ff @(posedge clk) begin
		if (reset) begin
			coin_x <= cell_x_t'(`COIN_LFSR_SEED);
			coin_y <= cell_y_t'(`COIN_LFSR_SEED >> `SNAKE_XBITS);
			score  <= '0;
		end else if (grow) begin
			// Low bits give x, high bits give y
			coin_x <= lfsr_next[`SNAKE_XBITS-1:0];
			coin_y <= lfsr_next[`SNAKE_XBITS +: `SNAKE_YBITS];
			if (score != '1)
				score <= score + 1'b1; // Saturate
		end
	end

	assign coin_query = (coin_x == query_x) && (coin_y == query_y);

endmodule

//--- snake_segment.sv
`timescale 1ns/1ps
`include "snake_cfg.svh"

module snake_segment #(
	parameter int INDEX = 0
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                step,
	input  logic                grow,
	input  snake_pkg::cell_x_t  prev_x,
	input  snake_pkg::cell_y_t  prev_y,
	input  logic                prev_active,
	input  snake_pkg::cell_x_t  next_x,
	input  snake_pkg::cell_y_t  next_y,
	input  snake_pkg::cell_x_t  query_x,
	input  snake_pkg::cell_y_t  query_y,
	output snake_pkg::cell_x_t  seg_x,
	output snake_pkg::cell_y_t  seg_y,
	output logic                seg_active,
	output logic                body_hit,
	output logic                query_hit
);

	import snake_pkg::*;

	// Starting body lies in a row left of the head
	localparam bit RESET_ACTIVE = (INDEX < `SNAKE_START_LEN - 1);
	localparam cell_x_t RESET_X = cell_x_t'(`SNAKE_START_X - 1 - INDEX);

	always_ff @(posedge clk) begin
		if (reset) begin
			seg_x      <= RESET_X;
			seg_y      <= cell_y_t'(`SNAKE_START_Y);
			seg_active <= RESET_ACTIVE;
		end else if (step) begin
			seg_x <= prev_x;
			seg_y <= prev_y;
			// First idle segment behind the tail joins on a coin
			seg_active <= seg_active | (grow & prev_active);
		end
	end

	assign body_hit  = seg_active && (seg_x == next_x) && (seg_y == next_y);
	assign query_hit = seg_active && (seg_x == query_x) && (seg_y == query_y);

endmodule

//--- snake_head.sv
`timescale 1ns/1ps
`include "snake_cfg.svh"

module snake_head (
	input  logic                clk,
	input  logic                reset,
	input  logic                game_tick,
	input  logic                move_valid,
	input  snake_pkg::dir_t     move,
	input  logic                self_hit,
	output logic                step,
	output snake_pkg::cell_x_t  next_x,
	output snake_pkg::cell_y_t  next_y,
	output snake_pkg::cell_x_t  head_x,
	output snake_pkg::cell_y_t  head_y,
	output logic                game_over
);

	import snake_pkg::*;

	dir_t        cur_dir;
	dir_t        pend_dir;
	dir_t        eff_dir;
	game_state_t state;
	logic        wall_hit;

	// A reversal would run straight into the neck, so keep going
	assign eff_dir = (pend_dir == dir_t'(cur_dir ^ 2'b10)) ? cur_dir : pend_dir;

	////////////////////////////////////////
	// Neighbour cell and wall check
	////////////////////////////////////////

	always_comb begin
		next_x   = head_x;
		next_y   = head_y;
		wall_hit = 1'b0;
		case (eff_dir)
			DIR_RIGHT: begin
				next_x   = head_x + 1'b1;
				wall_hit = (head_x == cell_x_t'(`SNAKE_H - 1));
			end
			DIR_UP: begin
				next_y   = head_y - 1'b1; // Row 0 is the top
				wall_hit = (head_y == '0);
			end
			DIR_LEFT: begin
				next_x   = head_x - 1'b1;
				wall_hit = (head_x == '0);
			end
			default: begin
				next_y   = head_y + 1'b1;
				wall_hit = (head_y == cell_y_t'(`SNAKE_V - 1));
			end
		endcase
	end

	// Only a legal move is broadcast to the chain and the coin
	assign step = game_tick && (state == ST_RUN) && !wall_hit && !self_hit;
	assign game_over = (state == ST_OVER);

	////////////////////////////////////////
	// Direction, position and game state
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= ST_RUN;
			cur_dir  <= DIR_RIGHT;
			pend_dir <= DIR_RIGHT;
			head_x   <= cell_x_t'(`SNAKE_START_X);
			head_y   <= cell_y_t'(`SNAKE_START_Y);
		end else begin
			if (move_valid)
				pend_dir <= move;
			if (game_tick && state == ST_RUN) begin
				if (wall_hit || self_hit) begin
					state <= ST_OVER; // Head stays where it was
				end else begin
					head_x  <= next_x;
					head_y  <= next_y;
					cur_dir <= eff_dir;
				end
			end
		end
	end

endmodule

//--- snake_pkg.sv
package snake_pkg;

`include "snake_cfg.svh"

	////////////////////////////////////////
	// Coordinates and colours
	////////////////////////////////////////

	typedef logic [`SNAKE_XBITS-1:0] cell_x_t;
	typedef logic [`SNAKE_YBITS-1:0] cell_y_t;
	typedef logic [7:0] colour_t; // RGB332
	typedef logic [7:0] score_t;

	////////////////////////////////////////
	// Enums
	////////////////////////////////////////

	// Opposite directions differ in bit 1
	typedef enum logic [1:0] {
		DIR_RIGHT = 2'd0,
		DIR_UP    = 2'd1,
		DIR_LEFT  = 2'd2,
		DIR_DOWN  = 2'd3
	} dir_t;

	typedef enum logic {
		ST_RUN  = 1'b0,
		ST_OVER = 1'b1
	} game_state_t;

	// What a screen query lands on
	typedef enum logic [1:0] {
		CELL_BG    = 2'd0,
		CELL_SNAKE = 2'd1,
		CELL_COIN  = 2'd2
	} cell_kind_t;

endpackage

//--- snake_cfg.svh
`ifndef SNAKE_CFG_SVH
`define SNAKE_CFG_SVH

// Board size in cells
`define SNAKE_H 32
`define SNAKE_V 32
`define SNAKE_XBITS 5
`define SNAKE_YBITS 5

// Head plus body segments
`define SNAKE_MAX_LEN 16
`define SNAKE_START_LEN 3
`define SNAKE_START_X 10
`define SNAKE_START_Y 10

// Screen placement of the board
`define SNAKE_POS_X 10
`define SNAKE_POS_Y 10
`define SNAKE_SCALE_SHIFT 1 // 2 screen pixels per cell

// RGB332 colours
`define SNAKE_COLOR_SNAKE 8'b111_111_11
`define SNAKE_COLOR_COIN 8'b111_111_00
`define SNAKE_COLOR_BG 8'b000_000_00

`define COIN_LFSR_SEED 10'h14e // First coin at x 14, y 10

`endif
